// ==== filelist.f ====
source/rv_core_pkg.sv
source/decode_if.sv
source/fetch_sequencer.sv
source/inst_decoder.sv
source/reg_file.sv
source/exec_alu.sv
source/load_store_unit.sv
source/rv_core.sv
tb/tb_rv_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the rv_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_rv_core \
    -f filelist.f \
    -o sim_tb_rv_core

out=$(./obj_dir/sim_tb_rv_core)
echo "$out"
echo "$out" | grep -q "TEST PASS"

// ==== tb/tb_rv_core.sv ====
`timescale 1ns/100ps

module tb_rv_core;
    import rv_core_pkg::*;

    localparam logic [31:0] RESET_PC  = 32'h0000_0100;
    localparam logic [31:0] DATA_BASE = 32'h0001_0000;
    localparam int PROG_LEN = 200;
    localparam int LAST_IDX = PROG_LEN + 31;
    localparam int LIMIT    = 231 * 10;
    localparam int MAX_WAIT = 4;

    logic inst_selfdefine, reset, if_valid, if_ready, mem_valid, mem_write, mem_ready;
    logic [31:0] if_addr, if_rdata, mem_addr, mem_wdata, mem_rdata;
    logic [3:0]  mem_wmask;

    integer seed = 56289;
    int errors, checks, timeouts, cycles, if_wait, mem_wait;
    logic done, if_fire, mem_fire, if_hold, mem_hold;
    logic [31:0] imem [0:255];
    logic [31:0] dut_mem [0:63];
    logic [31:0] m_mem [0:63];
    logic [31:0] m_reg [0:31];
    logic [31:0] m_pc, hold_if_addr, hold_addr, hold_wdata;
    logic [3:0]  hold_mask;
    logic        hold_write;
    // next data access the model expects
    logic        exp_pending, exp_write;
    logic [31:0] exp_addr, exp_wdata;
    logic [3:0]  exp_mask;

    rv_core #(.RESET_PC(RESET_PC)) rv_core_i (.*);

    assign if_rdata  = imem[8'((if_addr - RESET_PC) >> 2)];
    assign mem_rdata = dut_mem[6'((mem_addr - DATA_BASE) >> 2)];

    initial begin
        inst_selfdefine = 1'b0;
        forever #50 inst_selfdefine = ~inst_selfdefine;
    end

    function automatic int rnd(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic logic [31:0] fill_word(input logic [31:0] a);
        return (a * 32'h9E37_79B1) ^ {a[15:0], a[31:16]} ^ 32'h5A5A_1234;
    endfunction

    function automatic logic [31:0] enc_i(opcode_e op, int f3, int rd, int rs1, int imm);
        return {12'(imm), 5'(rs1), 3'(f3), 5'(rd), op};
    endfunction

    function automatic logic [31:0] enc_r(int alt, int f3, int rd, int rs1, int rs2);
        return {1'b0, 1'(alt), 5'b0, 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), OP_REG};
    endfunction

    function automatic logic [31:0] enc_s(int f3, int rs1, int rs2, int imm);
        logic [11:0] v;
        v = 12'(imm);
        return {v[11:5], 5'(rs2), 5'(rs1), 3'(f3), v[4:0], OP_STORE};
    endfunction

    function automatic logic [31:0] enc_b(int f3, int rs1, int rs2, int imm);
        logic [12:0] v;
        v = 13'(imm);
        return {v[12], v[10:5], 5'(rs2), 5'(rs1), 3'(f3), v[4:1], v[11], OP_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(int rd, int imm);
        logic [20:0] v;
        v = 21'(imm);
        return {v[20], v[10:1], v[11], v[19:12], 5'(rd), OP_JAL};
    endfunction

    // x1 holds the data base throughout, so random ops write x2..x31 only
    task automatic gen_program();
        int lf3 [5] = '{0, 1, 2, 4, 5};
        int bf3 [6] = '{0, 1, 4, 5, 6, 7};
        int f3, imm, tgt;
        imem[0] = {20'h00010, 5'd1, OP_LUI};
        for (int i = 1; i < PROG_LEN; i++) begin
            tgt = i + 1 + rnd(3);
            if (tgt > PROG_LEN) begin
                tgt = PROG_LEN;
            end
            case (rnd(10))
                0, 1, 2: begin
                    f3 = rnd(8);
                    imem[i] = enc_r((f3 == 0 || f3 == 5) ? rnd(2) : 0, f3, 2 + rnd(30),
                                    rnd(32), rnd(32));
                end
                3, 4: begin
                    f3  = rnd(8);
                    imm = (f3 == 1) ? rnd(32) : (f3 == 5) ? rnd(32) + 1024 * rnd(2) : rnd(4096);
                    imem[i] = enc_i(OP_IMM, f3, 2 + rnd(30), rnd(32), imm);
                end
                5: imem[i] = {20'(rnd(1 << 20)), 5'(2 + rnd(30)), OP_LUI};
                6: begin
                    f3 = lf3[rnd(5)];
                    imem[i] = enc_i(OP_LOAD, f3, 2 + rnd(30), 1, rnd(256) & ~((1 << (f3 % 4)) - 1));
                end
                7: begin
                    f3 = rnd(3);
                    imem[i] = enc_s(f3, 1, rnd(32), rnd(256) & ~((1 << f3) - 1));
                end
                8: imem[i] = enc_b(bf3[rnd(6)], rnd(32), rnd(32), (tgt - i) * 4);
                default: begin
                    // jalr from x0 with an absolute target, bit 0 sometimes set
                    if (rnd(2) == 0)
                        imem[i] = enc_j(2 + rnd(30), (tgt - i) * 4);
                    else
                        imem[i] = enc_i(OP_JALR, 0, 2 + rnd(30), 0,
                                        int'(RESET_PC) + tgt * 4 + rnd(2));
                end
            endcase
        end
        for (int k = 1; k < 32; k++) begin
            imem[PROG_LEN + k - 1] = enc_s(2, 1, k, 4 * k);
        end
        imem[LAST_IDX] = enc_j(0, 0);
    endtask

    function automatic logic [31:0] alu(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'b0, $signed(a) < $signed(b)};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic taken(input logic [2:0] f3, input logic [31:0] a,
                                   input logic [31:0] b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            default: return a >= b;
        endcase
    endfunction

    // instruction set model, one instruction per call
    task automatic step(input logic [31:0] ins);
        logic [31:0] a, b, immi, imms, res, npc, word, addr;
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic        wr;
        logic [5:0]  idx;
        a    = m_reg[ins[19:15]];
        b    = m_reg[ins[24:20]];
        rd   = ins[11:7];
        f3   = ins[14:12];
        immi = {{20{ins[31]}}, ins[31:20]};
        imms = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        npc  = m_pc + 32'd4;
        wr   = 1'b1;
        res  = '0;
        addr = (ins[6:0] == OP_STORE) ? a + imms : a + immi;
        idx  = 6'((addr - DATA_BASE) >> 2);
        case (ins[6:0])
            OP_LUI: res = {ins[31:12], 12'b0};
            OP_JAL: begin
                res = m_pc + 32'd4;
                npc = m_pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            OP_JALR: begin
                res = m_pc + 32'd4;
                npc = (a + immi) & ~32'h1;
            end
            OP_BRANCH: begin
                wr = 1'b0;
                if (taken(f3, a, b))
                    npc = m_pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            end
            OP_LOAD: begin
                word = m_mem[idx] >> (8 * addr[1:0]);
                case (f3)
                    3'd0:    res = {{24{word[7]}}, word[7:0]};
                    3'd1:    res = {{16{word[15]}}, word[15:0]};
                    3'd4:    res = {24'b0, word[7:0]};
                    3'd5:    res = {16'b0, word[15:0]};
                    default: res = word;
                endcase
                exp_pending = 1'b1;
                exp_write   = 1'b0;
                exp_addr    = addr;
            end
            OP_STORE: begin
                wr = 1'b0;
                exp_mask  = (f3 == 3'd0) ? 4'b0001 << addr[1:0] :
                            (f3 == 3'd1) ? 4'b0011 << addr[1:0] : 4'b1111;
                exp_wdata = b << (8 * addr[1:0]);
                exp_pending = 1'b1;
                exp_write   = 1'b1;
                exp_addr    = addr;
                for (int k = 0; k < 4; k++) begin
                    if (exp_mask[k]) m_mem[idx][8*k +: 8] = exp_wdata[8*k +: 8];
                end
            end
            OP_IMM: res = alu(f3, ins[30] && f3 == 3'd5, a, immi);
            OP_REG: res = alu(f3, ins[30], a, b);
            default: wr = 1'b0;
        endcase
        if (wr && rd != 5'd0) m_reg[rd] = res;
        m_pc = npc;
    endtask

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    // ready drops for 0 to 3 cycles after each transfer
    always @(posedge inst_selfdefine) begin
        cycles <= cycles + 1;
        if (if_fire) begin
            if_wait  <= rnd(MAX_WAIT);
            if_ready <= 1'b0;
        end else if (!if_ready) begin
            if (if_wait == 0) if_ready <= 1'b1;
            else if_wait <= if_wait - 1;
        end
        if (mem_fire) begin
            mem_wait  <= rnd(MAX_WAIT);
            mem_ready <= 1'b0;
        end else if (!mem_ready) begin
            if (mem_wait == 0) mem_ready <= 1'b1;
            else mem_wait <= mem_wait - 1;
        end
    end

    // outputs sampled mid-cycle where they are settled
    always @(negedge inst_selfdefine) begin
        if_fire  = !reset && if_valid && if_ready;
        mem_fire = !reset && mem_valid && mem_ready;
        if (!reset && !done) begin
            if (if_hold) check_value("if_addr held", hold_if_addr, if_addr);
            if (mem_hold) begin
                check_value("mem_addr held", hold_addr, mem_addr);
                check_value("mem_write held", 32'(hold_write), 32'(mem_write));
                check_value("mem_wdata held", hold_wdata, mem_wdata);
                check_value("mem_wmask held", 32'(hold_mask), 32'(mem_wmask));
            end
            if_hold      = if_valid && !if_ready;
            hold_if_addr = if_addr;
            mem_hold     = mem_valid && !mem_ready;
            hold_addr    = mem_addr;
            hold_write   = mem_write;
            hold_wdata   = mem_wdata;
            hold_mask    = mem_wmask;
            if (mem_fire) begin
                if (!exp_pending) begin
                    errors++;
                    $display("data access at %0t where the model expects none", $time);
                end else begin
                    check_value("mem_write", 32'(exp_write), 32'(mem_write));
                    check_value("mem_addr", exp_addr, mem_addr);
                    if (exp_write) begin
                        check_value("mem_wmask", 32'(exp_mask), 32'(mem_wmask));
                        for (int k = 0; k < 4; k++) begin
                            if (exp_mask[k]) begin
                                check_value("mem_wdata lane", 32'(exp_wdata[8*k +: 8]),
                                            32'(mem_wdata[8*k +: 8]));
                                dut_mem[6'((mem_addr - DATA_BASE) >> 2)][8*k +: 8] =
                                    mem_wdata[8*k +: 8];
                            end
                        end
                    end
                end
                exp_pending = 1'b0;
            end
            if (if_fire) begin
                check_value("if_addr", m_pc, if_addr);
                if (exp_pending) begin
                    errors++;
                    $display("instruction at %h ended without its data access", m_pc);
                    exp_pending = 1'b0;
                end
                if (m_pc == RESET_PC + 32'(LAST_IDX * 4)) done = 1'b1;
                else step(imem[8'((m_pc - RESET_PC) >> 2)]);
            end
        end
    end

    initial begin
        reset       <= 1'b1;
        if_ready    <= 1'b1;
        mem_ready   <= 1'b1;
        cycles      <= 0;
        if_wait     <= 0;
        mem_wait    <= 0;
        done        = 1'b0;
        exp_pending = 1'b0;
        if_hold     = 1'b0;
        mem_hold    = 1'b0;
        if_fire     = 1'b0;
        mem_fire    = 1'b0;
        errors      = 0;
        checks      = 0;
        timeouts    = 0;
        m_pc = RESET_PC;
        for (int i = 0; i < 256; i++) imem[i] = 32'h0000_0013;
        for (int i = 0; i < 32; i++) m_reg[i] = '0;
        for (int i = 0; i < 64; i++) begin
            dut_mem[i] = fill_word(DATA_BASE + 32'(4 * i));
            m_mem[i]   = dut_mem[i];
        end
        gen_program();
        repeat (4) @(posedge inst_selfdefine);
        reset <= 1'b0;
        @(negedge inst_selfdefine);
        check_value("mem_valid", 32'd0, 32'(mem_valid));
        check_value("if_valid", 32'd1, 32'(if_valid));
        check_value("if_addr", RESET_PC, if_addr);
        wait (done || cycles > LIMIT);
        if (!done) begin
            timeouts++;
            $display("timeout: the core did not reach the end of the program in %0d cycles",
                     LIMIT);
        end
        $display("checks: %0d  errors: %0d  timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== source/rv_core.sv ====
`timescale 1ns/100ps

module rv_core #(
    parameter logic [rv_core_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                            inst_selfdefine,
    input  logic                            reset,
    output logic                            if_valid,
    output logic [rv_core_pkg::XLEN-1:0]    if_addr,
    input  logic                            if_ready,
    input  logic [rv_core_pkg::XLEN-1:0]    if_rdata,
    output logic                            mem_valid,
    output logic                            mem_write,
    output logic [rv_core_pkg::XLEN-1:0]    mem_addr,
    output logic [rv_core_pkg::XLEN-1:0]    mem_wdata,
    output logic [rv_core_pkg::STRB_W-1:0]  mem_wmask,
    input  logic                            mem_ready,
    input  logic [rv_core_pkg::XLEN-1:0]    mem_rdata
);
    import rv_core_pkg::*;

    logic [31:0]     inst;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] next_pc;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] wb_data;
    logic            executing;
    logic            commit;
    logic            mem_stall;

    decode_if dec_bus ();

    fetch_sequencer #(
        .RESET_PC (RESET_PC)
    ) fetch_sequencer_i (
        .inst_selfdefine (inst_selfdefine),
        .reset           (reset),
        .if_ready        (if_ready),
        .if_rdata        (if_rdata),
        .next_pc         (next_pc),
        .mem_stall       (mem_stall),
        .if_valid        (if_valid),
        .if_addr         (if_addr),
        .inst            (inst),
        .pc              (pc),
        .executing       (executing),
        .commit          (commit)
    );

    inst_decoder inst_decoder_i (
        .inst (inst),
        .dec  (dec_bus.decoder)
    );

    reg_file reg_file_i (
        .inst_selfdefine (inst_selfdefine),
        .reset           (reset),
        .dec             (dec_bus.regs),
        .commit          (commit),
        .wb_data         (wb_data),
        .rs1_data        (rs1_data),
        .rs2_data        (rs2_data)
    );

    exec_alu exec_alu_i (
        .dec        (dec_bus.exec),
        .pc         (pc),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .alu_result (alu_result),
        .next_pc    (next_pc)
    );

    load_store_unit load_store_unit_i (
        .inst_selfdefine (inst_selfdefine),
        .reset           (reset),
        .dec             (dec_bus.lsu),
        .executing       (executing),
        .alu_result      (alu_result),
        .rs2_data        (rs2_data),
        .mem_ready       (mem_ready),
        .mem_rdata       (mem_rdata),
        .mem_valid       (mem_valid),
        .mem_write       (mem_write),
        .mem_addr        (mem_addr),
        .mem_wdata       (mem_wdata),
        .mem_wmask       (mem_wmask),
        .mem_stall       (mem_stall),
        .wb_data         (wb_data)
    );

endmodule

// ==== source/load_store_unit.sv ====
`timescale 1ns/100ps

module load_store_unit (
    input  logic                            inst_selfdefine,
    input  logic                            reset,
    decode_if.lsu                           dec,
    input  logic                            executing,
    input  logic [rv_core_pkg::XLEN-1:0]    alu_result,
    input  logic [rv_core_pkg::XLEN-1:0]    rs2_data,
    input  logic                            mem_ready,
    input  logic [rv_core_pkg::XLEN-1:0]    mem_rdata,
    output logic                            mem_valid,
    output logic                            mem_write,
    output logic [rv_core_pkg::XLEN-1:0]    mem_addr,
    output logic [rv_core_pkg::XLEN-1:0]    mem_wdata,
    output logic [rv_core_pkg::STRB_W-1:0]  mem_wmask,
    output logic                            mem_stall,
    output logic [rv_core_pkg::XLEN-1:0]    wb_data
);
    import rv_core_pkg::*;

    logic [1:0]        offset;
    logic [STRB_W-1:0] lane_mask;
    logic [XLEN-1:0]   rdata_shifted;
    logic [XLEN-1:0]   load_data;

    assign offset = alu_result[1:0];

    assign mem_valid = executing && (dec.is_load || dec.is_store);
    assign mem_write = dec.is_store;
    assign mem_addr  = alu_result;
    assign mem_stall = mem_valid && !mem_ready;

    // store data moved into its byte lane
    assign mem_wdata = rs2_data << {offset, 3'b000};

    always_comb begin
        case (dec.mem_size)
            SIZE_BYTE: lane_mask = STRB_W'(1) << offset;
            SIZE_HALF: lane_mask = STRB_W'(3) << offset;
            default:   lane_mask = '1;
        endcase
    end

    assign mem_wmask = dec.is_store ? lane_mask : '0;

    assign rdata_shifted = mem_rdata >> {offset, 3'b000};

    always_comb begin
        case (dec.mem_size)
            SIZE_BYTE:
                load_data = {{(XLEN-8){~dec.load_unsigned & rdata_shifted[7]}},
                             rdata_shifted[7:0]};
            SIZE_HALF:
                load_data = {{(XLEN-16){~dec.load_unsigned & rdata_shifted[15]}},
                             rdata_shifted[15:0]};
            default:
                load_data = rdata_shifted;
        endcase
    end

    assign wb_data = dec.is_load ? load_data : alu_result;

    // access held until the memory takes it
    assert property (@(posedge inst_selfdefine) disable iff (reset)
        mem_valid && !mem_ready |=> mem_valid && $stable(mem_addr) && $stable(mem_wdata));

endmodule

// ==== source/exec_alu.sv ====
`timescale 1ns/100ps

module exec_alu (
    decode_if.exec                        dec,
    input  logic [rv_core_pkg::XLEN-1:0]  pc,
    input  logic [rv_core_pkg::XLEN-1:0]  rs1_data,
    input  logic [rv_core_pkg::XLEN-1:0]  rs2_data,
    output logic [rv_core_pkg::XLEN-1:0]  alu_result,
    output logic [rv_core_pkg::XLEN-1:0]  next_pc
);
    import rv_core_pkg::*;

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_out;
    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] jump_target;
    logic [XLEN-1:0] branch_target;
    logic [4:0]      shamt;
    logic            taken;

    assign op_a  = dec.src_pc ? pc : rs1_data;
    assign op_b  = dec.src_imm ? dec.imm : rs2_data;
    assign shamt = op_b[4:0];

    always_comb begin
        case (dec.alu_op)
            ALU_SUB:    alu_out = op_a - op_b;
            ALU_AND:    alu_out = op_a & op_b;
            ALU_OR:     alu_out = op_a | op_b;
            ALU_XOR:    alu_out = op_a ^ op_b;
            ALU_SLT:    alu_out = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:   alu_out = {{(XLEN-1){1'b0}}, op_a < op_b};
            ALU_SLL:    alu_out = op_a << shamt;
            ALU_SRL:    alu_out = op_a >> shamt;
            ALU_SRA:    alu_out = $signed(op_a) >>> shamt;
            ALU_PASS_B: alu_out = op_b;
            default:    alu_out = op_a + op_b;
        endcase
    end

    // branch compare always on the register operands
    always_comb begin
        case (dec.cmp)
            CMP_NE:  taken = rs1_data != rs2_data;
            CMP_LT:  taken = $signed(rs1_data) < $signed(rs2_data);
            CMP_GE:  taken = $signed(rs1_data) >= $signed(rs2_data);
            CMP_LTU: taken = rs1_data < rs2_data;
            CMP_GEU: taken = rs1_data >= rs2_data;
            default: taken = rs1_data == rs2_data;
        endcase
    end

    assign pc_plus4      = pc + XLEN'(4);
    assign branch_target = pc + dec.imm;
    assign jump_target   = {alu_out[XLEN-1:1], alu_out[0] & ~dec.is_jalr};

    // link value for jumps
    assign alu_result = dec.is_jump ? pc_plus4 : alu_out;

    assign next_pc = dec.is_jump                ? jump_target   :
                     (dec.is_branch && taken)   ? branch_target : pc_plus4;

endmodule

// ==== source/reg_file.sv ====
`timescale 1ns/100ps

module reg_file (
    input  logic                          inst_selfdefine,
    input  logic                          reset,
    decode_if.regs                        dec,
    input  logic                          commit,
    input  logic [rv_core_pkg::XLEN-1:0]  wb_data,
    output logic [rv_core_pkg::XLEN-1:0]  rs1_data,
    output logic [rv_core_pkg::XLEN-1:0]  rs2_data
);
    import rv_core_pkg::*;

    // x0 has no storage
    logic [XLEN-1:0] regs [1:31];

    always_ff @(posedge inst_selfdefine) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (commit && dec.rd_en && (dec.rd_index != '0)) begin
            regs[dec.rd_index] <= wb_data;
        end
    end

    assign rs1_data = (dec.rs1_index == '0) ? '0 : regs[dec.rs1_index];
    assign rs2_data = (dec.rs2_index == '0) ? '0 : regs[dec.rs2_index];

    assert property (@(posedge inst_selfdefine) disable iff (reset)
        dec.rs1_index == '0 |-> rs1_data == '0);

endmodule

// ==== source/inst_decoder.sv ====
`timescale 1ns/100ps

module inst_decoder (
    input  logic [31:0]     inst,
    decode_if.decoder       dec
);
    import rv_core_pkg::*;

    opcode_e         opcode;
    logic [2:0]      funct3;
    logic            funct7_alt;
    mem_size_e       size_dec;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;

    // funct3 to ALU op, alt selects sub and sra
    function automatic alu_op_e alu_from_funct(input logic [2:0] f3, input logic alt);
        alu_op_e op;
        case (f3)
            3'b000:  op = alt ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    assign opcode     = opcode_e'(inst[6:0]);
    assign funct3     = inst[14:12];
    assign funct7_alt = inst[30];

    assign imm_i = {{(XLEN-12){inst[31]}}, inst[31:20]};
    assign imm_s = {{(XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{(XLEN-13){inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {{(XLEN-32){inst[31]}}, inst[31:12], 12'b0};
    assign imm_j = {{(XLEN-21){inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    // funct3 low bits 11 falls back to word
    assign size_dec = (funct3[1:0] == 2'b00) ? SIZE_BYTE :
                      (funct3[1:0] == 2'b01) ? SIZE_HALF : SIZE_WORD;

    assign dec.rs1_index = inst[19:15];
    assign dec.rs2_index = inst[24:20];
    assign dec.rd_index  = inst[11:7];

    always_comb begin
        dec.rd_en         = 1'b0;
        dec.imm           = '0;
        dec.alu_op        = ALU_ADD;
        dec.src_pc        = 1'b0;
        dec.src_imm       = 1'b0;
        dec.is_branch     = 1'b0;
        dec.is_jump       = 1'b0;
        dec.is_jalr       = 1'b0;
        dec.cmp           = CMP_EQ;
        dec.is_load       = 1'b0;
        dec.is_store      = 1'b0;
        dec.mem_size      = size_dec;
        dec.load_unsigned = funct3[2];
        case (opcode)
            OP_LUI: begin
                dec.rd_en   = 1'b1;
                dec.imm     = imm_u;
                dec.src_imm = 1'b1;
                dec.alu_op  = ALU_PASS_B;
            end
            OP_JAL: begin
                // ALU forms the target, link comes from pc + 4
                dec.rd_en   = 1'b1;
                dec.imm     = imm_j;
                dec.src_pc  = 1'b1;
                dec.src_imm = 1'b1;
                dec.is_jump = 1'b1;
            end
            OP_JALR: begin
                dec.rd_en   = 1'b1;
                dec.imm     = imm_i;
                dec.src_imm = 1'b1;
                dec.is_jump = 1'b1;
                dec.is_jalr = 1'b1;
            end
            OP_BRANCH: begin
                dec.imm       = imm_b;
                dec.is_branch = (funct3 != 3'b010) && (funct3 != 3'b011);
                dec.cmp       = cmp_e'(funct3);
            end
            OP_LOAD: begin
                dec.rd_en   = 1'b1;
                dec.imm     = imm_i;
                dec.src_imm = 1'b1;
                dec.is_load = 1'b1;
            end
            OP_STORE: begin
                dec.imm      = imm_s;
                dec.src_imm  = 1'b1;
                dec.is_store = 1'b1;
            end
            OP_IMM: begin
                dec.rd_en   = 1'b1;
                dec.imm     = imm_i;
                dec.src_imm = 1'b1;
                dec.alu_op  = alu_from_funct(funct3, (funct3 == 3'b101) && funct7_alt);
            end
            OP_REG: begin
                dec.rd_en  = 1'b1;
                dec.alu_op = alu_from_funct(funct3, funct7_alt);
            end
            default: ;
        endcase
    end

endmodule

// ==== source/fetch_sequencer.sv ====
`timescale 1ns/100ps

module fetch_sequencer #(
    parameter logic [rv_core_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                          inst_selfdefine,
    input  logic                          reset,
    input  logic                          if_ready,
    input  logic [rv_core_pkg::XLEN-1:0]  if_rdata,
    input  logic [rv_core_pkg::XLEN-1:0]  next_pc,
    input  logic                          mem_stall,
    output logic                          if_valid,
    output logic [rv_core_pkg::XLEN-1:0]  if_addr,
    output logic [31:0]                   inst,
    output logic [rv_core_pkg::XLEN-1:0]  pc,
    output logic                          executing,
    output logic                          commit
);
    import rv_core_pkg::*;

    typedef enum logic {
        FETCH,
        EXECUTE
    } state_e;

    // addi x0, x0, 0
    localparam logic [31:0] NOP = 32'h0000_0013;

    state_e state;

    always_ff @(posedge inst_selfdefine) begin
        if (reset) begin
            state <= FETCH;
            pc    <= RESET_PC;
            inst  <= NOP;
        end else begin
            case (state)
                FETCH: begin
                    if (if_ready) begin
                        inst  <= if_rdata[31:0];
                        state <= EXECUTE;
                    end
                end
                EXECUTE: begin
                    // hold here while the data port is stalled
                    if (!mem_stall) begin
                        pc    <= next_pc;
                        state <= FETCH;
                    end
                end
                default: state <= FETCH;
            endcase
        end
    end

    assign if_valid  = (state == FETCH);
    assign if_addr   = pc;
    assign executing = (state == EXECUTE);
    assign commit    = executing && !mem_stall;

    // request held until accepted
    assert property (@(posedge inst_selfdefine) disable iff (reset)
        if_valid && !if_ready |=> if_valid && $stable(if_addr));

endmodule

// ==== source/decode_if.sv ====
`timescale 1ns/100ps

interface decode_if;
    import rv_core_pkg::*;

    logic [REG_INDEX_W-1:0] rs1_index;
    logic [REG_INDEX_W-1:0] rs2_index;
    logic [REG_INDEX_W-1:0] rd_index;
    logic                   rd_en;
    logic [XLEN-1:0]        imm;
    alu_op_e                alu_op;
    logic                   src_pc;
    logic                   src_imm;
    logic                   is_branch;
    logic                   is_jump;
    logic                   is_jalr;
    cmp_e                   cmp;
    logic                   is_load;
    logic                   is_store;
    mem_size_e              mem_size;
    logic                   load_unsigned;

    modport decoder (
        output rs1_index, rs2_index, rd_index, rd_en, imm, alu_op, src_pc, src_imm,
               is_branch, is_jump, is_jalr, cmp, is_load, is_store, mem_size, load_unsigned
    );

    modport regs (input rs1_index, rs2_index, rd_index, rd_en);

    modport exec (input imm, alu_op, src_pc, src_imm, is_branch, is_jump, is_jalr, cmp);

    modport lsu (input is_load, is_store, mem_size, load_unsigned);

endinterface

// ==== source/rv_core_pkg.sv ====
package rv_core_pkg;

    parameter int XLEN        = 32;
    parameter int REG_INDEX_W = 5;
    parameter int STRB_W      = 4;

    // major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_PASS_B
    } alu_op_e;

    // values follow branch funct3
    typedef enum logic [2:0] {
        CMP_EQ  = 3'b000,
        CMP_NE  = 3'b001,
        CMP_LT  = 3'b100,
        CMP_GE  = 3'b101,
        CMP_LTU = 3'b110,
        CMP_GEU = 3'b111
    } cmp_e;

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10
    } mem_size_e;

endpackage
